// File: hw/tile_pkg.sv
// Bus widths, slave indices, region codes, address union and boot image
`default_nettype none

package tile_pkg;

   localparam int ADDR_WIDTH   = 32;
   localparam int DATA_WIDTH   = 32;
   localparam int SEL_WIDTH    = DATA_WIDTH / 8; // One select per byte lane
   localparam int REGION_WIDTH = 4;

   localparam logic [REGION_WIDTH-1:0] REGION_MEM  = 4'h0; // Local data memory
   localparam logic [REGION_WIDTH-1:0] REGION_BOOT = 4'hf; // Boot ROM

   localparam int NR_SLAVES  = 2;
   localparam int SLAVE_MEM  = 0;
   localparam int SLAVE_BOOT = 1;

   localparam int BOOT_WORDS = 16; // Power of two, index wraps

   // Small boot stub, jumps into the local memory after setting up a stack
   localparam logic [DATA_WIDTH-1:0] BOOT_IMAGE [0:BOOT_WORDS-1] = '{
      32'h1820_0000, 32'ha821_0ffc, 32'h1860_0000, 32'ha863_0100,
      32'h1880_dead, 32'ha884_beef, 32'hd403_2000, 32'h8463_0000,
      32'he0a0_2800, 32'h1900_0000, 32'h4400_4000, 32'h1500_0000,
      32'h1500_0000, 32'h0000_0000, 32'h1500_0000, 32'hcafe_f00d
   };

   // One address word, seen flat or split into region and offset
   typedef union packed {
      logic [ADDR_WIDTH-1:0] flat;
      struct packed {
         logic [REGION_WIDTH-1:0]            region;
         logic [ADDR_WIDTH-REGION_WIDTH-1:0] offset;
      } seg;
   } bus_addr_t;

endpackage

`default_nettype wire

// File: hw/wb_arbiter.sv
// Round-robin Wishbone classic arbiter with one-hot grant and response routing
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
   parameter int NR_MASTERS = 3
) (
   input  logic                                              clk,
   input  logic                                              reset_i,

   input  logic [NR_MASTERS-1:0]                             m_cyc_i,
   input  logic [NR_MASTERS-1:0]                             m_stb_i,
   input  logic [NR_MASTERS-1:0]                             m_we_i,
   input  logic [NR_MASTERS-1:0][tile_pkg::ADDR_WIDTH-1:0]   m_adr_i,
   input  logic [NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0]   m_dat_i,
   input  logic [NR_MASTERS-1:0][tile_pkg::SEL_WIDTH-1:0]    m_sel_i,
   output logic [NR_MASTERS-1:0]                             m_ack_o,
   output logic [NR_MASTERS-1:0]                             m_err_o,
   output logic [NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0]   m_dat_o,

   output logic                                              bus_cyc_o,
   output logic                                              bus_stb_o,
   output logic                                              bus_we_o,
   output tile_pkg::bus_addr_t                               bus_adr_o,
   output logic [tile_pkg::DATA_WIDTH-1:0]                   bus_dat_o,
   output logic [tile_pkg::SEL_WIDTH-1:0]                    bus_sel_o,
   input  logic                                              bus_ack_i,
   input  logic                                              bus_err_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0]                   bus_dat_i
);

   localparam int PTR_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

   logic [NR_MASTERS-1:0] grant_q, grant_d;
   logic [PTR_W-1:0]      rr_ptr_q, rr_ptr_d; // Last granted master

   // Search starts one past the last winner
   always_comb begin
      int unsigned idx;
      logic        found;
      grant_d  = '0;
      rr_ptr_d = rr_ptr_q;
      found    = 1'b0;
      for (int k = 1; k <= NR_MASTERS; k++) begin
         idx = (int'(rr_ptr_q) + k) % NR_MASTERS;
         if (!found && m_cyc_i[idx]) begin
            found         = 1'b1;
            grant_d[idx]  = 1'b1;
            rr_ptr_d      = PTR_W'(idx);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         grant_q  <= '0;
         rr_ptr_q <= PTR_W'(NR_MASTERS - 1); // First search hits master 0
      end else if (!bus_cyc_o) begin         // Re-arbitrate only when idle
         grant_q  <= grant_d;
         if (|grant_d) rr_ptr_q <= rr_ptr_d;
      end
   end

   assign bus_cyc_o = |(grant_q & m_cyc_i);
   assign bus_stb_o = |(grant_q & m_cyc_i & m_stb_i);

   always_comb begin
      bus_we_o  = 1'b0;
      bus_adr_o = '0;
      bus_dat_o = '0;
      bus_sel_o = '0;
      for (int i = 0; i < NR_MASTERS; i++) begin
         if (grant_q[i]) begin
            bus_we_o  = m_we_i[i];
            bus_adr_o = m_adr_i[i];
            bus_dat_o = m_dat_i[i];
            bus_sel_o = m_sel_i[i];
         end
      end
   end

   for (genvar m = 0; m < NR_MASTERS; m++) begin : g_resp
      assign m_ack_o[m] = grant_q[m] & bus_ack_i;
      assign m_err_o[m] = grant_q[m] & bus_err_i;
      assign m_dat_o[m] = grant_q[m] ? bus_dat_i : '0; // Others see zero
   end

   a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0(grant_q));

endmodule

`default_nettype wire

// File: hw/wb_addr_decoder.sv
// Region decoder selecting memory or boot ROM, with error response and return mux
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decoder #(
   parameter int MEM_WORDS = 256
) (
   input  logic                                                      clk,
   input  logic                                                      reset_i,

   input  logic                                                      bus_cyc_i,
   input  logic                                                      bus_stb_i,
   input  logic                                                      bus_we_i,
   input  tile_pkg::bus_addr_t                                       bus_adr_i,
   output logic                                                      bus_ack_o,
   output logic                                                      bus_err_o,
   output logic [tile_pkg::DATA_WIDTH-1:0]                           bus_dat_o,

   output logic [tile_pkg::NR_SLAVES-1:0]                            s_stb_o,
   input  logic [tile_pkg::NR_SLAVES-1:0]                            s_ack_i,
   input  logic [tile_pkg::NR_SLAVES-1:0][tile_pkg::DATA_WIDTH-1:0]  s_dat_i
);

   logic                                                     req;
   logic [31:0]                                              word_idx;
   logic                                                     mem_in_range;
   logic [tile_pkg::NR_SLAVES-1:0]                           hit;
   logic [tile_pkg::NR_SLAVES-1:0][tile_pkg::DATA_WIDTH-1:0] dat_masked;
   logic                                                     err_q;

   assign req          = bus_cyc_i & bus_stb_i;
   assign word_idx     = 32'(bus_adr_i.seg.offset >> 2); // Byte offset to word
   assign mem_in_range = (word_idx < MEM_WORDS);

   always_comb begin
      hit = '0;
      case (bus_adr_i.seg.region)
         tile_pkg::REGION_MEM:  hit[tile_pkg::SLAVE_MEM]  = mem_in_range;
         tile_pkg::REGION_BOOT: hit[tile_pkg::SLAVE_BOOT] = !bus_we_i; // Read only
         default:               hit = '0;                              // Unmapped
      endcase
   end

   for (genvar s = 0; s < tile_pkg::NR_SLAVES; s++) begin : g_slave
      assign s_stb_o[s]    = req & hit[s];
      assign dat_masked[s] = s_ack_i[s] ? s_dat_i[s] : '0;
   end

   // Blocked or unmapped access answers like a slave, one cycle later
   always_ff @(posedge clk) begin
      if (reset_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & ~(|hit) & ~err_q;
      end
   end

   assign bus_ack_o = |s_ack_i;
   assign bus_err_o = err_q;

   always_comb begin
      bus_dat_o = '0;
      for (int s = 0; s < tile_pkg::NR_SLAVES; s++) begin
         bus_dat_o = bus_dat_o | dat_masked[s];
      end
   end

   // Slave acks and the local error come from disjoint address decodes
   a_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(bus_ack_o && bus_err_o));

endmodule

`default_nettype wire

// File: hw/wb_sram_sp.sv
// Single-port data memory with byte selects as a Wishbone classic slave
`timescale 1ns/1ps
`default_nettype none

module wb_sram_sp #(
   parameter int MEM_WORDS = 256
) (
   input  logic                            clk,
   input  logic                            reset_i,

   input  logic                            stb_i,
   input  logic                            we_i,
   input  tile_pkg::bus_addr_t             adr_i,
   input  logic [tile_pkg::DATA_WIDTH-1:0] dat_i,
   input  logic [tile_pkg::SEL_WIDTH-1:0]  sel_i,
   output logic                            ack_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   logic [tile_pkg::DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];
   logic [IDX_W-1:0]                word_idx;
   logic                            ack_q;
   logic [tile_pkg::DATA_WIDTH-1:0] dat_q;

   assign word_idx = adr_i.flat[IDX_W+1:2]; // Drop byte offset

   // Ack one cycle after stb, then low for a cycle
   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i & ~ack_q;
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i && we_i && !ack_q) begin
         for (int b = 0; b < tile_pkg::SEL_WIDTH; b++) begin
            if (sel_i[b]) mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8]; // Byte lane
         end
      end
      dat_q <= mem[word_idx]; // Valid together with ack on reads
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

   a_ack_after_stb: assert property (@(posedge clk) disable iff (reset_i)
      $rose(ack_o) |-> $past(stb_i));

endmodule

`default_nettype wire

// File: hw/bootrom.sv
// Read-only boot image as a Wishbone classic slave
`timescale 1ns/1ps
`default_nettype none

module bootrom (
   input  logic                            clk,
   input  logic                            reset_i,

   input  logic                            stb_i,
   input  tile_pkg::bus_addr_t             adr_i,
   output logic                            ack_o,
   output logic [tile_pkg::DATA_WIDTH-1:0] dat_o
);

   localparam int BOOT_IDX_W = $clog2(tile_pkg::BOOT_WORDS);

   logic [BOOT_IDX_W-1:0]           boot_idx;
   logic                            ack_q;
   logic [tile_pkg::DATA_WIDTH-1:0] dat_q;

   assign boot_idx = adr_i.flat[BOOT_IDX_W+1:2]; // Wraps over the image

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i & ~ack_q;
      end
   end

   always_ff @(posedge clk) begin
      dat_q <= tile_pkg::BOOT_IMAGE[boot_idx];
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

endmodule

`default_nettype wire

// File: hw/compute_tile_bus.sv
// Shared tile bus: arbiter, region decoder, data memory and boot ROM
`timescale 1ns/1ps
`default_nettype none

module compute_tile_bus #(
   parameter int NR_MASTERS = 3,
   parameter int MEM_WORDS  = 256
) (
   input  logic                                              clk,
   input  logic                                              reset_i,

   input  logic [NR_MASTERS-1:0]                             m_cyc_i,
   input  logic [NR_MASTERS-1:0]                             m_stb_i,
   input  logic [NR_MASTERS-1:0]                             m_we_i,
   input  logic [NR_MASTERS-1:0][tile_pkg::ADDR_WIDTH-1:0]   m_adr_i,
   input  logic [NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0]   m_dat_i,
   input  logic [NR_MASTERS-1:0][tile_pkg::SEL_WIDTH-1:0]    m_sel_i,
   output logic [NR_MASTERS-1:0]                             m_ack_o,
   output logic [NR_MASTERS-1:0]                             m_err_o,
   output logic [NR_MASTERS-1:0][tile_pkg::DATA_WIDTH-1:0]   m_dat_o
);

   // Shared bus between arbiter and decoder
   logic                            bus_cyc;
   logic                            bus_stb;
   logic                            bus_we;
   tile_pkg::bus_addr_t             bus_adr;
   logic [tile_pkg::DATA_WIDTH-1:0] bus_dat_w;
   logic [tile_pkg::SEL_WIDTH-1:0]  bus_sel;
   logic                            bus_ack;
   logic                            bus_err;
   logic [tile_pkg::DATA_WIDTH-1:0] bus_dat_r;

   logic [tile_pkg::NR_SLAVES-1:0]                           s_stb;
   logic [tile_pkg::NR_SLAVES-1:0]                           s_ack;
   logic [tile_pkg::NR_SLAVES-1:0][tile_pkg::DATA_WIDTH-1:0] s_dat;

   wb_arbiter #(
      .NR_MASTERS (NR_MASTERS)
   ) i_wb_arbiter (
      .clk       (clk),
      .reset_i   (reset_i),
      .m_cyc_i   (m_cyc_i),
      .m_stb_i   (m_stb_i),
      .m_we_i    (m_we_i),
      .m_adr_i   (m_adr_i),
      .m_dat_i   (m_dat_i),
      .m_sel_i   (m_sel_i),
      .m_ack_o   (m_ack_o),
      .m_err_o   (m_err_o),
      .m_dat_o   (m_dat_o),
      .bus_cyc_o (bus_cyc),
      .bus_stb_o (bus_stb),
      .bus_we_o  (bus_we),
      .bus_adr_o (bus_adr),
      .bus_dat_o (bus_dat_w),
      .bus_sel_o (bus_sel),
      .bus_ack_i (bus_ack),
      .bus_err_i (bus_err),
      .bus_dat_i (bus_dat_r)
   );

   wb_addr_decoder #(
      .MEM_WORDS (MEM_WORDS)
   ) i_wb_addr_decoder (
      .clk       (clk),
      .reset_i   (reset_i),
      .bus_cyc_i (bus_cyc),
      .bus_stb_i (bus_stb),
      .bus_we_i  (bus_we),
      .bus_adr_i (bus_adr),
      .bus_ack_o (bus_ack),
      .bus_err_o (bus_err),
      .bus_dat_o (bus_dat_r),
      .s_stb_o   (s_stb),
      .s_ack_i   (s_ack),
      .s_dat_i   (s_dat)
   );

   wb_sram_sp #(
      .MEM_WORDS (MEM_WORDS)
   ) i_wb_sram_sp (
      .clk     (clk),
      .reset_i (reset_i),
      .stb_i   (s_stb[tile_pkg::SLAVE_MEM]),
      .we_i    (bus_we),
      .adr_i   (bus_adr),
      .dat_i   (bus_dat_w),
      .sel_i   (bus_sel),
      .ack_o   (s_ack[tile_pkg::SLAVE_MEM]),
      .dat_o   (s_dat[tile_pkg::SLAVE_MEM])
   );

   bootrom i_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .stb_i   (s_stb[tile_pkg::SLAVE_BOOT]), // Writes never get here
      .adr_i   (bus_adr),
      .ack_o   (s_ack[tile_pkg::SLAVE_BOOT]),
      .dat_o   (s_dat[tile_pkg::SLAVE_BOOT])
   );

endmodule

`default_nettype wire

// File: testbench/tb_compute_tile_bus.sv
// Directed testbench for the shared tile bus with reference memory model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_compute_tile_bus;

   localparam int NR_MASTERS    = 3;
   localparam int MEM_WORDS     = 256;
   localparam int CLK_PERIOD    = 100;
   localparam int RESET_CYCLES  = 10;
   localparam int ACCESS_CYCLES = 20; // Budget per access, covers contention

   localparam int MWR_WORDS   = 8;
   localparam int NR_SELS     = 6;
   localparam int BOOT_READS  = 20;
   localparam int ARB_ROUNDS  = 2;
   localparam int NR_ACCESSES = 2 * MWR_WORDS + 1 + 2 * NR_SELS + BOOT_READS + 2 + 4
                                + 2 * NR_MASTERS * ARB_ROUNDS;
   localparam int WATCHDOG_NS = (NR_ACCESSES * ACCESS_CYCLES + RESET_CYCLES) * CLK_PERIOD;

   localparam logic [3:0] SEL_LIST [NR_SELS] = '{
      4'b0001, 4'b0100, 4'b1000, 4'b0010, 4'b0011, 4'b1100
   };

   logic                         clk = 1'b0;
   logic                         reset_i;
   logic [NR_MASTERS-1:0]        m_cyc_i;
   logic [NR_MASTERS-1:0]        m_stb_i;
   logic [NR_MASTERS-1:0]        m_we_i;
   logic [NR_MASTERS-1:0][31:0]  m_adr_i;
   logic [NR_MASTERS-1:0][31:0]  m_dat_i;
   logic [NR_MASTERS-1:0][3:0]   m_sel_i;
   logic [NR_MASTERS-1:0]        m_ack_o;
   logic [NR_MASTERS-1:0]        m_err_o;
   logic [NR_MASTERS-1:0][31:0]  m_dat_o;

   logic [31:0] ref_mem [0:MEM_WORDS-1]; // Expected memory contents
   int          ack_count [NR_MASTERS];  // Acks seen per master
   integer      seed = 59;

   compute_tile_bus #(
      .NR_MASTERS (NR_MASTERS),
      .MEM_WORDS  (MEM_WORDS)
   ) i_compute_tile_bus (
      .clk     (clk),
      .reset_i (reset_i),
      .m_cyc_i (m_cyc_i),
      .m_stb_i (m_stb_i),
      .m_we_i  (m_we_i),
      .m_adr_i (m_adr_i),
      .m_dat_i (m_dat_i),
      .m_sel_i (m_sel_i),
      .m_ack_o (m_ack_o),
      .m_err_o (m_err_o),
      .m_dat_o (m_dat_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("sim failed");
      $fatal(1, "Run stopped at the first failing check");
   endtask

   function automatic logic [31:0] word_addr(input logic [3:0] region, input int idx);
      return {region, 28'(idx * 4)}; // Word index to byte address
   endfunction

   // Reference byte-lane update
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  sel);
      logic [31:0] merged;
      merged = old_word;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) merged[8*b +: 8] = new_word[8*b +: 8];
      end
      return merged;
   endfunction

   task automatic expect_ack(input int m, input logic ack, input logic err, input string what);
      assert (ack && !err) else
         abort_run($sformatf("ERROR at %0t ns: master %0d %s expected ack, got ack=%0b err=%0b",
                             $time, m, what, ack, err));
   endtask

   task automatic expect_err(input int m, input logic ack, input logic err, input string what);
      assert (err && !ack) else
         abort_run($sformatf("ERROR at %0t ns: master %0d %s expected err, got ack=%0b err=%0b",
                             $time, m, what, ack, err));
   endtask

   task automatic expect_data(input int m, input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      assert (got === exp) else
         abort_run($sformatf("ERROR at %0t ns: master %0d %s read %h, expected %h",
                             $time, m, what, got, exp));
   endtask

   // One Wishbone classic cycle, held until ack or err
   task automatic bus_access(input int m, input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, input logic [3:0] sel,
                             output logic [31:0] rdat, output logic ack, output logic err);
      int waited;
      waited = 0;
      @(posedge clk);
      m_cyc_i[m] <= 1'b1;
      m_stb_i[m] <= 1'b1;
      m_we_i[m]  <= we;
      m_adr_i[m] <= adr;
      m_dat_i[m] <= wdat;
      m_sel_i[m] <= sel;
      @(negedge clk);
      while (!m_ack_o[m] && !m_err_o[m]) begin
         assert (waited < ACCESS_CYCLES) else
            abort_run($sformatf("Master %0d got neither ack nor err within %0d cycles",
                                m, ACCESS_CYCLES));
         waited++;
         @(negedge clk);
      end
      ack  = m_ack_o[m];
      err  = m_err_o[m];
      rdat = m_dat_o[m];
      @(posedge clk);
      m_cyc_i[m] <= 1'b0;
      m_stb_i[m] <= 1'b0;
      m_we_i[m]  <= 1'b0;
   endtask

   // Answers never overlap, and nothing answers during reset
   always @(negedge clk) begin
      assert (!(|(m_ack_o & m_err_o)) && $onehot0(m_ack_o | m_err_o)) else
         abort_run($sformatf("ERROR at %0t ns: overlapping answers ack=%b err=%b",
                             $time, m_ack_o, m_err_o));
      if (reset_i) begin
         assert (m_ack_o == '0 && m_err_o == '0) else
            abort_run($sformatf("ERROR at %0t ns: answer during reset ack=%b err=%b",
                                $time, m_ack_o, m_err_o));
      end
      for (int m = 0; m < NR_MASTERS; m++) begin
         if (m_ack_o[m]) ack_count[m]++;
      end
   end

   task automatic check_idle_after_reset();
      repeat (3) begin
         @(negedge clk);
         assert (m_ack_o == '0 && m_err_o == '0) else
            abort_run($sformatf("ERROR at %0t ns: answer right after reset ack=%b err=%b",
                                $time, m_ack_o, m_err_o));
      end
   endtask

   task automatic test_mem_write_read();
      logic [31:0] wdat;
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      for (int i = 0; i < MWR_WORDS; i++) begin
         wdat = $random(seed);
         bus_access(0, 1'b1, word_addr(tile_pkg::REGION_MEM, 3 * i + 1), wdat, 4'hf,
                    rdat, ack, err);
         expect_ack(0, ack, err, "memory write");
         ref_mem[3 * i + 1] = wdat;
      end
      for (int i = 0; i < MWR_WORDS; i++) begin
         bus_access(0, 1'b0, word_addr(tile_pkg::REGION_MEM, 3 * i + 1), '0, 4'hf,
                    rdat, ack, err);
         expect_ack(0, ack, err, "memory read");
         expect_data(0, rdat, ref_mem[3 * i + 1], "memory read");
      end
   endtask

   task automatic test_byte_selects();
      logic [31:0] wdat;
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      int          idx;
      idx  = 40;
      wdat = $random(seed);
      bus_access(0, 1'b1, word_addr(tile_pkg::REGION_MEM, idx), wdat, 4'hf, rdat, ack, err);
      expect_ack(0, ack, err, "full word write");
      ref_mem[idx] = wdat;
      for (int i = 0; i < NR_SELS; i++) begin
         wdat = $random(seed);
         bus_access(0, 1'b1, word_addr(tile_pkg::REGION_MEM, idx), wdat, SEL_LIST[i],
                    rdat, ack, err);
         expect_ack(0, ack, err, "partial write");
         ref_mem[idx] = merge_bytes(ref_mem[idx], wdat, SEL_LIST[i]);
         bus_access(0, 1'b0, word_addr(tile_pkg::REGION_MEM, idx), '0, 4'hf, rdat, ack, err);
         expect_ack(0, ack, err, "partial readback");
         expect_data(0, rdat, ref_mem[idx], "partial readback");
      end
   endtask

   task automatic test_boot_rom();
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      int          idx;
      for (int i = 0; i < BOOT_READS; i++) begin
         idx = 5 * i; // Stride 5 visits every image word, then wraps
         bus_access(1, 1'b0, word_addr(tile_pkg::REGION_BOOT, idx), '0, 4'hf, rdat, ack, err);
         expect_ack(1, ack, err, "boot ROM read");
         expect_data(1, rdat, tile_pkg::BOOT_IMAGE[idx % tile_pkg::BOOT_WORDS], "boot ROM read");
      end
      bus_access(2, 1'b1, word_addr(tile_pkg::REGION_BOOT, 3), 32'h0bad_c0de, 4'hf,
                 rdat, ack, err);
      expect_err(2, ack, err, "boot ROM write");
      bus_access(2, 1'b0, word_addr(tile_pkg::REGION_BOOT, 3), '0, 4'hf, rdat, ack, err);
      expect_ack(2, ack, err, "boot ROM read after write");
      expect_data(2, rdat, tile_pkg::BOOT_IMAGE[3], "boot ROM read after write");
   endtask

   task automatic test_error_responses();
      logic [31:0] rdat;
      logic        ack;
      logic        err;
      bus_access(0, 1'b0, word_addr(4'he, 7), '0, 4'hf, rdat, ack, err);
      expect_err(0, ack, err, "unmapped read");
      bus_access(1, 1'b1, word_addr(4'h3, 2), 32'h1234_5678, 4'hf, rdat, ack, err);
      expect_err(1, ack, err, "unmapped write");
      bus_access(0, 1'b0, word_addr(tile_pkg::REGION_MEM, MEM_WORDS), '0, 4'hf, rdat, ack, err);
      expect_err(0, ack, err, "read beyond memory");
      bus_access(2, 1'b1, word_addr(tile_pkg::REGION_MEM, MEM_WORDS + 5), 32'hffff_0000, 4'hf,
                 rdat, ack, err);
      expect_err(2, ack, err, "write beyond memory");
   endtask

   task automatic test_arbitration();
      logic [31:0] wdat [NR_MASTERS];
      logic [31:0] rdat [NR_MASTERS];
      logic        ack [NR_MASTERS];
      logic        err [NR_MASTERS];
      int          acks_before [NR_MASTERS];
      int          base;
      for (int r = 0; r < ARB_ROUNDS; r++) begin
         base = 100 + 8 * r;
         for (int m = 0; m < NR_MASTERS; m++) begin
            acks_before[m] = ack_count[m];
            wdat[m]        = $random(seed);
         end
         fork // All masters request in the same cycle
            bus_access(0, 1'b1, word_addr(tile_pkg::REGION_MEM, base), wdat[0], 4'hf,
                       rdat[0], ack[0], err[0]);
            bus_access(1, 1'b1, word_addr(tile_pkg::REGION_MEM, base + 1), wdat[1], 4'hf,
                       rdat[1], ack[1], err[1]);
            bus_access(2, 1'b1, word_addr(tile_pkg::REGION_MEM, base + 2), wdat[2], 4'hf,
                       rdat[2], ack[2], err[2]);
         join
         for (int m = 0; m < NR_MASTERS; m++) begin
            expect_ack(m, ack[m], err[m], "contended write");
            assert (ack_count[m] == acks_before[m] + 1) else
               abort_run($sformatf("ERROR at %0t ns: master %0d saw %0d acks for one write",
                                   $time, m, ack_count[m] - acks_before[m]));
            ref_mem[base + m] = wdat[m];
         end
         for (int m = 0; m < NR_MASTERS; m++) begin
            bus_access(m, 1'b0, word_addr(tile_pkg::REGION_MEM, base + m), '0, 4'hf,
                       rdat[m], ack[m], err[m]);
            expect_ack(m, ack[m], err[m], "readback after contention");
            expect_data(m, rdat[m], ref_mem[base + m], "readback after contention");
         end
      end
   endtask

   initial begin
      reset_i <= 1'b1;
      m_cyc_i <= '0;
      m_stb_i <= '0;
      m_we_i  <= '0;
      m_adr_i <= '0;
      m_dat_i <= '0;
      m_sel_i <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_i <= 1'b0;
      check_idle_after_reset();
      test_mem_write_read();
      test_byte_selects();
      test_boot_rom();
      test_error_responses();
      test_arbitration();
      $display("sim passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
      $display("sim failed");
      $fatal(1, "Watchdog timeout");
   end

endmodule

`default_nettype wire

// File: compute_tile_bus.f
hw/tile_pkg.sv
hw/wb_arbiter.sv
hw/wb_addr_decoder.sv
hw/wb_sram_sp.sv
hw/bootrom.sv
hw/compute_tile_bus.sv
testbench/tb_compute_tile_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tile bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_compute_tile_bus -f compute_tile_bus.f

status=0
output=$(./obj_dir/Vtb_compute_tile_bus 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "sim passed"; then
   echo "Run OK"
   exit 0
fi
echo "Run FAILED (exit status $status)" >&2
exit 1
